//--- list.f
design/corr_pkg.sv
design/operand_mem.sv
design/mem_arbiter.sv
design/srl_stage.sv
design/sipo_y.sv
design/x_stream.sv
design/pe_mac.sv
design/corr_top.sv
dv/corr_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the correlation engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module corr_tb -o corr_sim

# tee keeps the log even when the simulation stops on an error
./obj_dir/corr_sim 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi

echo "simulation finished, see sim.log"
exit 0

//--- dv/corr_tb.sv
`timescale 1ns/1ps

module corr_tb import corr_pkg::*; ();

   // cycles allowed from start to result_valid
   localparam int RUN_TIMEOUT = 2000;
   localparam int RUN_COUNT = 5;

   logic       clk;
   logic       rst;
   mem_wr_t    wr;
   logic       start;
   logic       busy;
   acc_array_t result;
   logic       result_valid;

   // host-side copy of the operand memory
   cplx_t x_vals [X_WORDS];
   cplx_t y_vals [Y_WORDS];
   string test_name;
   int    valid_cnt;
   int    sum_re;
   int    sum_im;

   corr_top dut_i (
      .clk          (clk),
      .rst          (rst),
      .wr           (wr),
      .start        (start),
      .busy         (busy),
      .result       (result),
      .result_valid (result_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // checking and reference
   //////////////////////////////////////////////////////////////////////

   task automatic check_val(input string name, input int expected, input int actual);
      if (expected != actual) begin
         $display("Error %s expected %0d actual %0d", name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // pe i sees y block (PE_NUM-1-i+p) mod PE_NUM in pass p
   function automatic int ref_half(input int pe, input bit want_im);
      int sum;
      int blk;
      int xr;
      int xi;
      int yr;
      int yi;
      sum = 0;
      for (int p = 0; p < ITER_NUM; p++) begin
         blk = (PE_NUM - 1 - pe + p) % PE_NUM;
         for (int k = 0; k < REG_NUM; k++) begin
            xr = int'(x_vals[p * REG_NUM + k].re);
            xi = int'(x_vals[p * REG_NUM + k].im);
            yr = int'(y_vals[blk * REG_NUM + k].re);
            yi = int'(y_vals[blk * REG_NUM + k].im);
            if (want_im) begin
               sum = sum + xr * yi + xi * yr;
            end else begin
               sum = sum + xr * yr - xi * yi;
            end
         end
      end
      return sum;
   endfunction

   // compares every accumulator on each result_valid
   always @(negedge clk) begin
      if (!rst && result_valid) begin
         for (int pe = 0; pe < PE_NUM; pe++) begin
            check_val($sformatf("%s pe%0d re", test_name, pe),
                      ref_half(pe, 1'b0), int'(result[pe].re));
            check_val($sformatf("%s pe%0d im", test_name, pe),
                      ref_half(pe, 1'b1), int'(result[pe].im));
         end
         valid_cnt++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////////////////////////

   // x is (1,0) so each pe just sums y
   task automatic fill_unit();
      for (int a = 0; a < X_WORDS; a++) begin
         x_vals[a].re = 8'd1;
         x_vals[a].im = 8'd0;
      end
      // ramp with the im part going negative
      for (int a = 0; a < Y_WORDS; a++) begin
         y_vals[a].re = 8'(a);
         y_vals[a].im = 8'(3 * a - 50);
      end
   endtask

   task automatic fill_random(input bit extremes);
      for (int a = 0; a < X_WORDS; a++) begin
         x_vals[a].re = 8'($urandom);
         x_vals[a].im = 8'($urandom);
      end
      for (int a = 0; a < Y_WORDS; a++) begin
         y_vals[a].re = 8'($urandom);
         y_vals[a].im = 8'($urandom);
      end
      if (extremes) begin
         // corner products with -128 * -128 and mixed signs
         x_vals[0].re = 8'h80;
         x_vals[0].im = 8'h80;
         y_vals[0].re = 8'h7f;
         y_vals[0].im = 8'h80;
         x_vals[X_WORDS-1].re = 8'h7f;
         x_vals[X_WORDS-1].im = 8'h7f;
         y_vals[Y_WORDS-1].re = 8'h80;
         y_vals[Y_WORDS-1].im = 8'h80;
         y_vals[REG_NUM].re = 8'h80;
         x_vals[REG_NUM].im = 8'h7f;
      end
   endtask

   // one word per cycle with the y block first
   task automatic load_mem();
      for (int a = 0; a < Y_WORDS; a++) begin
         @(posedge clk);
         #1;
         wr.en   = 1'b1;
         wr.addr = ADDR_WIDTH'(Y_BASE + a);
         wr.data = y_vals[a];
      end
      for (int a = 0; a < X_WORDS; a++) begin
         @(posedge clk);
         #1;
         wr.en   = 1'b1;
         wr.addr = ADDR_WIDTH'(X_BASE + a);
         wr.data = x_vals[a];
      end
      @(posedge clk);
      #1;
      wr.en = 1'b0;
   endtask

   // both status outputs stay low while idle
   task automatic idle_check(input string name, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         @(negedge clk);
         check_val({name, " busy"}, 0, int'(busy));
         check_val({name, " result_valid"}, 0, int'(result_valid));
      end
   endtask

   task automatic run_case(input string name);
      int cycles;
      int prev_cnt;
      bit done;
      test_name = name;
      prev_cnt  = valid_cnt;
      cycles    = 0;
      done      = 1'b0;
      @(posedge clk);
      #1;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      // busy from the cycle after start up to result_valid
      while (!done) begin
         @(negedge clk);
         check_val({name, " busy"}, 1, int'(busy));
         if (result_valid) begin
            done = 1'b1;
         end else begin
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
               $display("timeout, no result_valid within %0d cycles in %s",
                        RUN_TIMEOUT, name);
               $display("TESTS FAILED");
               $fatal(1, "run timeout");
            end
         end
      end
      // single pulse and back to idle
      idle_check({name, " after"}, 10);
      check_val({name, " result_valid count"}, prev_cnt + 1, valid_cnt);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      // one seed for the whole run
      void'($urandom(38585));
      rst       = 1'b1;
      start     = 1'b0;
      wr        = '0;
      valid_cnt = 0;
      test_name = "reset";
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;

      idle_check("reset idle", 20);

      // with unit x every pe ends with the plain y sums
      fill_unit();
      load_mem();
      run_case("unit");
      sum_re = 0;
      sum_im = 0;
      for (int a = 0; a < Y_WORDS; a++) begin
         sum_re = sum_re + int'(y_vals[a].re);
         sum_im = sum_im + int'(y_vals[a].im);
      end
      for (int pe = 0; pe < PE_NUM; pe++) begin
         check_val($sformatf("unit sum pe%0d re", pe), sum_re, int'(result[pe].re));
         check_val($sformatf("unit sum pe%0d im", pe), sum_im, int'(result[pe].im));
      end

      fill_random(1'b1);
      load_mem();
      run_case("random extremes");

      // start must clear the old sums each time
      for (int r = 0; r < 3; r++) begin
         fill_random(1'b0);
         load_mem();
         run_case($sformatf("back to back %0d", r));
      end

      if (valid_cnt != RUN_COUNT) begin
         $display("Error result_valid total expected %0d actual %0d", RUN_COUNT, valid_cnt);
         $display("TESTS FAILED");
         $fatal(1, "wrong number of results");
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

//--- design/corr_top.sv
`timescale 1ns/1ps

module corr_top import corr_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  mem_wr_t    wr,
   input  logic       start,
   output logic       busy,
   output acc_array_t result,
   output logic       result_valid
);

   // memory read side
   rd_req_t               y_req;
   rd_req_t               x_req;
   logic                  y_gnt;
   logic                  x_gnt;
   logic [ADDR_WIDTH-1:0] rd_addr;
   cplx_t                 rd_data;

   // loader / streamer handshake
   logic               shift_v;
   logic               rotating;
   logic               pass_last;
   cplx_t              x_bcast;
   cplx_t [PE_NUM-1:0] y_par;
   acc_t               pe_acc [PE_NUM];

   // last pass is rotating
   logic               fin_now;
   logic               fin_q;

   operand_mem mem_i (
      .clk     (clk),
      .wr      (wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   mem_arbiter arb_i (
      .y_req   (y_req),
      .x_req   (x_req),
      .y_gnt   (y_gnt),
      .x_gnt   (x_gnt),
      .rd_addr (rd_addr)
   );

   sipo_y sipo_i (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .shift_v   (shift_v),
      .req       (y_req),
      .gnt       (y_gnt),
      .rd_data   (rd_data),
      .rotating  (rotating),
      .pass_last (pass_last),
      .p_out     (y_par)
   );

   x_stream xs_i (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .req       (x_req),
      .gnt       (x_gnt),
      .rd_data   (rd_data),
      .rotating  (rotating),
      .pass_last (pass_last),
      .shift_v   (shift_v),
      .x_bcast   (x_bcast)
   );

   //////////////////////////////////////////////////////////////////////
   // pe array, x broadcast to all
   //////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < PE_NUM; i++) begin : g_pe
      pe_mac pe_i (
         .clk    (clk),
         .rst    (rst),
         .clear  (start),
         .acc_en (rotating),
         .y      (y_par[i]),
         .x      (x_bcast),
         .acc    (pe_acc[i])
      );
   end

   // accumulators hold until the next start
   always_comb begin
      for (int i = 0; i < PE_NUM; i++) begin
         result[i] = pe_acc[i];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // run status
   //////////////////////////////////////////////////////////////////////

   assign fin_now = rotating && pass_last;

   always_ff @(posedge clk) begin
      if (rst) begin
         fin_q <= 1'b0;
         busy  <= 1'b0;
      end else begin
         fin_q <= fin_now;
         if (start) begin
            busy <= 1'b1;
         end else if (result_valid) begin
            busy <= 1'b0;
         end
      end
   end

   // falling edge of last pass rotation, accumulators final here
   assign result_valid = fin_q && !fin_now;

endmodule

//--- design/pe_mac.sv
`timescale 1ns/1ps

module pe_mac import corr_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  clear,
   input  logic  acc_en,
   input  cplx_t y,
   input  cplx_t x,
   output acc_t  acc
);

   // partial products
   logic signed [2*DATA_WIDTH-1:0] rr;
   logic signed [2*DATA_WIDTH-1:0] ii;
   logic signed [2*DATA_WIDTH-1:0] ri;
   logic signed [2*DATA_WIDTH-1:0] ir;
   // full complex product, one extra bit for the add
   logic signed [PROD_WIDTH-1:0]   prod_re;
   logic signed [PROD_WIDTH-1:0]   prod_im;

   always_comb begin
      rr = $signed(x.re) * $signed(y.re);
      ii = $signed(x.im) * $signed(y.im);
      ri = $signed(x.re) * $signed(y.im);
      ir = $signed(x.im) * $signed(y.re);
      // re = xr*yr - xi*yi
      prod_re = PROD_WIDTH'(rr) - PROD_WIDTH'(ii);
      // im = xr*yi + xi*yr
      prod_im = PROD_WIDTH'(ri) + PROD_WIDTH'(ir);
   end

   //////////////////////////////////////////////////////////////////////
   // accumulator
   //////////////////////////////////////////////////////////////////////

   // start clears, each rotate cycle adds one product
   always_ff @(posedge clk) begin
      if (rst || clear) begin
         acc <= '0;
      end else if (acc_en) begin
         acc.re <= acc.re + ACC_WIDTH'(prod_re);
         acc.im <= acc.im + ACC_WIDTH'(prod_im);
      end
   end

endmodule

//--- design/x_stream.sv
`timescale 1ns/1ps

module x_stream import corr_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    start,
   output rd_req_t req,
   input  logic    gnt,
   input  cplx_t   rd_data,
   input  logic    rotating,
   input  logic    pass_last,
   output logic    shift_v,
   output cplx_t   x_bcast
);

   xs_state_t state;

   // runs from X_BASE up across all passes
   logic [X_CNT_WIDTH-1:0]   x_addr;
   logic [REG_CNT_WIDTH-1:0] issue_cnt;
   logic [REG_IDX_WIDTH-1:0] fill_cnt;
   logic [REG_IDX_WIDTH-1:0] s_idx;
   logic                     x_vld;

   // one pass of x words
   cplx_t xbuf [REG_NUM];

   //////////////////////////////////////////////////////////////////////
   // moore outputs
   //////////////////////////////////////////////////////////////////////

   // held while denied, y loader wins any overlap
   always_comb begin
      req.req  = (state == X_FETCH) && (issue_cnt != REG_CNT_WIDTH'(REG_NUM));
      req.addr = ADDR_WIDTH'(X_BASE) + ADDR_WIDTH'(x_addr);
   end

   // drops after the first rotate cycle
   assign shift_v = (state == X_READY);
   assign x_bcast = xbuf[s_idx];

   //////////////////////////////////////////////////////////////////////
   // fsm
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= X_IDLE;
         x_addr    <= '0;
         issue_cnt <= '0;
         fill_cnt  <= '0;
         s_idx     <= '0;
         x_vld     <= 1'b0;
      end else begin
         x_vld <= req.req && gnt;
         case (state)
            X_IDLE: begin
               if (start) begin
                  state     <= X_FETCH;
                  x_addr    <= '0;
                  issue_cnt <= '0;
                  fill_cnt  <= '0;
                  s_idx     <= '0;
               end
            end
            X_FETCH: begin
               if (req.req && gnt) begin
                  x_addr    <= x_addr + 1'b1;
                  issue_cnt <= issue_cnt + 1'b1;
               end
               // full pass buffered
               if (x_vld) begin
                  fill_cnt <= fill_cnt + 1'b1;
                  if (fill_cnt == REG_IDX_WIDTH'(REG_NUM - 1)) begin
                     state <= X_READY;
                  end
               end
            end
            X_READY: begin
               // word 0 goes out in this cycle
               if (rotating) begin
                  s_idx <= s_idx + 1'b1;
                  state <= X_STREAM;
               end
            end
            X_STREAM: begin
               if (rotating) begin
                  s_idx <= s_idx + 1'b1;
                  if (s_idx == REG_IDX_WIDTH'(REG_NUM - 1)) begin
                     s_idx     <= '0;
                     issue_cnt <= '0;
                     fill_cnt  <= '0;
                     // no more fetches after the last pass
                     state     <= pass_last ? X_IDLE : X_FETCH;
                  end
               end
            end
            default: state <= X_IDLE;
         endcase
      end
   end

   // buffer fill, word order follows fetch order
   always_ff @(posedge clk) begin
      if (x_vld) begin
         xbuf[fill_cnt] <= rd_data;
      end
   end

endmodule

//--- design/sipo_y.sv
`timescale 1ns/1ps

module sipo_y import corr_pkg::*; (
   input  logic               clk,
   input  logic               rst,
   input  logic               start,
   input  logic               shift_v,
   output rd_req_t            req,
   input  logic               gnt,
   input  cplx_t              rd_data,
   output logic               rotating,
   output logic               pass_last,
   output cplx_t [PE_NUM-1:0] p_out
);

   sipo_state_t state;

   logic [Y_CNT_WIDTH-1:0]    y_addr_cnt;
   logic [Y_CNT_WIDTH-1:0]    ld_cnt;
   logic [REG_IDX_WIDTH-1:0]  shift_cnt;
   logic [PASS_CNT_WIDTH-1:0] pass_cnt;
   // granted last cycle, so rd_data holds a y word now
   logic                      y_vld;

   cplx_t ring_in;
   logic  stage_en;
   cplx_t srl_q [PE_NUM];

   //////////////////////////////////////////////////////////////////////
   // moore outputs
   //////////////////////////////////////////////////////////////////////

   // one request per cycle until every y word is issued
   always_comb begin
      req.req  = (state == LOAD) && (y_addr_cnt != Y_CNT_WIDTH'(Y_WORDS));
      req.addr = ADDR_WIDTH'(Y_BASE) + ADDR_WIDTH'(y_addr_cnt);
   end

   assign rotating  = (state == SHIFT);
   assign pass_last = (state != IDLE) && (pass_cnt == PASS_CNT_WIDTH'(ITER_NUM - 1));

   //////////////////////////////////////////////////////////////////////
   // fsm
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         y_addr_cnt <= '0;
         ld_cnt     <= '0;
         shift_cnt  <= '0;
         pass_cnt   <= '0;
         y_vld      <= 1'b0;
      end else begin
         y_vld <= req.req && gnt;
         case (state)
            IDLE: begin
               // fresh run, counters back to zero
               if (start) begin
                  state      <= LOAD;
                  y_addr_cnt <= '0;
                  ld_cnt     <= '0;
                  shift_cnt  <= '0;
                  pass_cnt   <= '0;
               end
            end
            LOAD: begin
               if (req.req && gnt) begin
                  y_addr_cnt <= y_addr_cnt + 1'b1;
               end
               // done once the last word has entered stage 0
               if (y_vld) begin
                  ld_cnt <= ld_cnt + 1'b1;
                  if (ld_cnt == Y_CNT_WIDTH'(Y_WORDS - 1)) begin
                     state <= WAIT;
                  end
               end
            end
            WAIT: begin
               // hold ring until x has a full pass buffered
               if (shift_v) begin
                  state <= SHIFT;
               end
            end
            SHIFT: begin
               shift_cnt <= shift_cnt + 1'b1;
               if (shift_cnt == REG_IDX_WIDTH'(REG_NUM - 1)) begin
                  shift_cnt <= '0;
                  if (pass_last) begin
                     state <= IDLE;
                  end else begin
                     pass_cnt <= pass_cnt + 1'b1;
                     state    <= WAIT;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage ring
   //////////////////////////////////////////////////////////////////////

   // memory feeds the ring while loading, last stage wraps while rotating
   assign ring_in  = rotating ? srl_q[PE_NUM-1] : rd_data;
   // whole ring moves together, otherwise frozen
   assign stage_en = y_vld || rotating;

   // first word loaded ends up at the head of the last stage
   for (genvar i = 0; i < PE_NUM; i++) begin : g_stage
      if (i == 0) begin : g_head
         srl_stage srl_i (
            .clk  (clk),
            .en   (stage_en),
            .din  (ring_in),
            .dout (srl_q[i])
         );
      end else begin : g_body
         srl_stage srl_i (
            .clk  (clk),
            .en   (stage_en),
            .din  (srl_q[i-1]),
            .dout (srl_q[i])
         );
      end
   end

   // every stage head, one per pe
   always_comb begin
      for (int i = 0; i < PE_NUM; i++) begin
         p_out[i] = srl_q[i];
      end
   end

endmodule

//--- design/srl_stage.sv
`timescale 1ns/1ps

module srl_stage import corr_pkg::*; (
   input  logic  clk,
   input  logic  en,
   input  cplx_t din,
   output cplx_t dout
);

   // tap 0 is newest, last tap oldest
   cplx_t taps [REG_NUM];

   always_ff @(posedge clk) begin
      if (en) begin
         taps[0] <= din;
         for (int i = 1; i < REG_NUM; i++) begin
            taps[i] <= taps[i-1];
         end
      end
   end

   // oldest word out
   assign dout = taps[REG_NUM-1];

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import corr_pkg::*; (
   input  rd_req_t               y_req,
   input  rd_req_t               x_req,
   output logic                  y_gnt,
   output logic                  x_gnt,
   output logic [ADDR_WIDTH-1:0] rd_addr
);

   //////////////////////////////////////////////////////////////////////
   // fixed priority, y loader first
   //////////////////////////////////////////////////////////////////////

   // purely combinational, no added latency
   always_comb begin
      y_gnt = y_req.req;
      // x only gets the port when y is quiet
      x_gnt = x_req.req && !y_req.req;
   end

   // winning address onto the memory
   // idle cycles just read whatever x points at, nobody samples it
   always_comb begin
      if (y_req.req) begin
         rd_addr = y_req.addr;
      end else begin
         rd_addr = x_req.addr;
      end
   end

endmodule

//--- design/operand_mem.sv
`timescale 1ns/1ps

module operand_mem import corr_pkg::*; (
   input  logic                  clk,
   input  mem_wr_t               wr,
   input  logic [ADDR_WIDTH-1:0] rd_addr,
   output cplx_t                 rd_data
);

   // y words at the bottom, x words above
   cplx_t mem [MEM_DEPTH];

   // host write port
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.addr] <= wr.data;
      end
   end

   // registered read, data one cycle after address
   // address comes straight from the arbiter mux
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

//--- design/corr_pkg.sv
package corr_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////

   // one signed half of a sample
   localparam int DATA_WIDTH = 8;
   // processing elements, also ring stages
   localparam int PE_NUM = 4;
   // stage depth and rotate cycles per pass
   localparam int REG_NUM = 8;
   // one pass per element so every y block visits every pe
   localparam int ITER_NUM = PE_NUM;

   // operand memory map, y block first then x
   localparam int Y_WORDS = PE_NUM * REG_NUM;
   localparam int X_WORDS = ITER_NUM * REG_NUM;
   localparam int Y_BASE = 0;
   localparam int X_BASE = Y_WORDS;
   localparam int MEM_DEPTH = Y_WORDS + X_WORDS;
   localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

   // accumulator half, plenty of headroom over the 17 bit products
   localparam int ACC_WIDTH = 24;
   localparam int PROD_WIDTH = 2 * DATA_WIDTH + 1;

   // counter widths
   localparam int Y_CNT_WIDTH = $clog2(Y_WORDS + 1);
   localparam int X_CNT_WIDTH = $clog2(X_WORDS + 1);
   localparam int REG_CNT_WIDTH = $clog2(REG_NUM + 1);
   localparam int REG_IDX_WIDTH = $clog2(REG_NUM);
   localparam int PASS_CNT_WIDTH = $clog2(ITER_NUM + 1);

   //////////////////////////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////////////////////////

   // one memory word
   typedef struct packed {
      logic signed [DATA_WIDTH-1:0] re;
      logic signed [DATA_WIDTH-1:0] im;
   } cplx_t;

   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] re;
      logic signed [ACC_WIDTH-1:0] im;
   } acc_t;

   // host write strobe
   typedef struct packed {
      logic                  en;
      logic [ADDR_WIDTH-1:0] addr;
      cplx_t                 data;
   } mem_wr_t;

   // reader request, held until granted
   typedef struct packed {
      logic                  req;
      logic [ADDR_WIDTH-1:0] addr;
   } rd_req_t;

   typedef acc_t [PE_NUM-1:0] acc_array_t;

   typedef enum logic [1:0] {IDLE, LOAD, WAIT, SHIFT} sipo_state_t;
   typedef enum logic [1:0] {X_IDLE, X_FETCH, X_READY, X_STREAM} xs_state_t;

endpackage
